//--- burst_splitter.f
+incdir+source
source/burst_splitter_pkg.sv
source/ar_splitter.sv
source/burst_len_fifo.sv
source/r_last_rebuild.sv
source/burst_splitter.sv
tb/tb_burst_splitter.sv

//--- Bender.yml
package:
  name: burst_splitter

sources:
  - include_dirs:
      - source
    files:
      - source/burst_splitter_pkg.sv
      - source/ar_splitter.sv
      - source/burst_len_fifo.sv
      - source/r_last_rebuild.sv
      - source/burst_splitter.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_burst_splitter.sv

//--- tb/tb_burst_splitter.sv
// -------------------------------------------------------------------------
// Testbench of the read burst splitter. Random upstream bursts and stalls
// drive the DUT; a downstream memory model answers each single-beat request
// and an upstream model checks addresses, data and rebuilt last flags.
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "burst_splitter_config.svh"

module tb_burst_splitter;

  import burst_splitter_pkg::*;

  localparam int unsigned num_bursts   = 40;
  localparam int unsigned max_txns     = `BS_MAX_READ_TXNS;
  localparam int unsigned limit_cycles = 40;
  // Random phase, limit phase and the burst left pending when it ends
  localparam int unsigned max_bursts   = num_bursts + max_txns + 1;
  localparam int unsigned timeout_cycles = max_bursts * 16 * 4 + limit_cycles + 400;

  localparam int unsigned mode_idle   = 0;
  localparam int unsigned mode_random = 1;
  localparam int unsigned mode_limit  = 2;
  localparam int unsigned mode_drain  = 3;

  logic   clk_i;
  logic   rst_n_i;
  addr_t  s_ar_addr_i;
  id_t    s_ar_id_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_e s_ar_burst_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  data_t  s_r_data_o;
  id_t    s_r_id_o;
  resp_t  s_r_resp_o;
  logic   s_r_last_o;
  logic   s_r_valid_o;
  logic   s_r_ready_i;
  addr_t  m_ar_addr_o;
  id_t    m_ar_id_o;
  size_t  m_ar_size_o;
  burst_e m_ar_burst_o;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i;
  data_t  m_r_data_i;
  id_t    m_r_id_i;
  resp_t  m_r_resp_i;
  logic   m_r_valid_i;
  logic   m_r_ready_o;

  // Accepted bursts in acceptance order
  addr_t  b_addr  [max_bursts];
  id_t    b_id    [max_bursts];
  len_t   b_len   [max_bursts];
  size_t  b_size  [max_bursts];
  burst_e b_burst [max_bursts];

  // Downstream memory model, one pending response per request
  data_t mem_data_q [$];
  id_t   mem_id_q   [$];

  int unsigned acc_cnt;
  int unsigned req_idx;
  int unsigned req_beat;
  int unsigned rsp_idx;
  int unsigned rsp_beat;
  int unsigned sent;
  int unsigned mode;
  int unsigned err_cnt;
  int unsigned err_start;
  int unsigned acc_start;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned cycle_cnt;
  logic        ar_taken;
  logic        r_taken;
  logic [31:0] rng_state;
  string       test_name;

  burst_splitter i_burst_splitter (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Address of beat k of a burst
  function automatic addr_t beat_addr(addr_t base, size_t size, burst_e burst,
                                      int unsigned beat);
    if (burst == burst_incr) begin
      return base + (addr_t'(beat) << size);
    end
    return base;
  endfunction

  // Memory model content, the ID sits in the top bits
  function automatic data_t model_data(addr_t addr, id_t id);
    return data_t'(addr) ^ (data_t'(id) << (`BS_DATA_WIDTH - `BS_ID_WIDTH));
  endfunction

  task automatic report_mismatch(string field, logic [63:0] expected, logic [63:0] actual);
    $display("mismatch %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
    err_cnt++;
  endtask

  task automatic report_failure(string msg);
    $display("error in %s: %s", test_name, msg);
    err_cnt++;
  endtask

  task automatic finish_test(int unsigned errors_before);
    if (err_cnt == errors_before) begin
      $display("test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", test_name, err_cnt - errors_before);
      tests_failed++;
    end
  endtask

  // Every accepted burst fully split and returned, no request pending
  task automatic wait_drained();
    while (s_ar_valid_i || (req_idx != acc_cnt) || (rsp_idx != acc_cnt) ||
           (mem_data_q.size() != 0) || ((mode == mode_random) && (sent < num_bursts))) begin
      @(posedge clk_i);
    end
  endtask

  task automatic start_burst(input logic short_len);
    logic [31:0] r;
    size_t       size;
    draw_random(r);
    s_ar_len_i = short_len ? len_t'(r[1:0]) : len_t'(r[3:0]);
    draw_random(r);
    size = size_t'(r % 3);
    s_ar_size_i = size;
    draw_random(r);
    s_ar_burst_i = r[0] ? burst_incr : burst_fixed;
    s_ar_id_i = id_t'(r >> 8);
    draw_random(r);
    s_ar_addr_i = addr_t'(r) & ~((addr_t'(1) << size) - addr_t'(1));
    s_ar_valid_i = 1'b1;
    sent++;
  endtask

  // -------------------------------------------------------------------------
  // Stimulus, 2 ns after each rising edge
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin : drive_inputs
    logic [31:0] r;
    #2;
    if (mode != mode_idle) begin
      draw_random(r);
      m_ar_ready_i = (mode == mode_limit) ? 1'b1 : (r[1:0] != 2'b00);
      draw_random(r);
      s_r_ready_i = (mode == mode_limit) ? 1'b0 : (r[1:0] != 2'b00);
      // Downstream R holds a beat until it is taken
      if (r_taken) begin
        m_r_valid_i = 1'b0;
        r_taken = 1'b0;
      end
      if (!m_r_valid_i && (mem_data_q.size() > 0)) begin
        draw_random(r);
        if (r[1:0] != 2'b00) begin
          m_r_valid_i = 1'b1;
          m_r_data_i = mem_data_q[0];
          m_r_id_i = mem_id_q[0];
          m_r_resp_i = '0;
        end
      end
      // Upstream AR
      if (ar_taken) begin
        s_ar_valid_i = 1'b0;
        ar_taken = 1'b0;
      end
      if (!s_ar_valid_i) begin
        draw_random(r);
        if (mode == mode_limit) begin
          start_burst(1'b1);
        end else if ((mode == mode_random) && (sent < num_bursts) && (r[1:0] != 2'b00)) begin
          start_burst(1'b0);
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Handshake checks at the falling edge
  // -------------------------------------------------------------------------
  always @(negedge clk_i) begin : check_handshakes
    addr_t exp_addr;
    data_t exp_data;
    logic  exp_last;
    if (rst_n_i) begin
      if (s_ar_valid_i && s_ar_ready_o) begin
        if (acc_cnt < max_bursts) begin
          b_addr[acc_cnt]  = s_ar_addr_i;
          b_id[acc_cnt]    = s_ar_id_i;
          b_len[acc_cnt]   = s_ar_len_i;
          b_size[acc_cnt]  = s_ar_size_i;
          b_burst[acc_cnt] = s_ar_burst_i;
          acc_cnt++;
        end else begin
          report_failure("more bursts were accepted than the testbench issued");
        end
        ar_taken = 1'b1;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (req_idx >= acc_cnt) begin
          report_failure("a downstream request appeared with no accepted burst pending");
        end else begin
          exp_addr = beat_addr(b_addr[req_idx], b_size[req_idx], b_burst[req_idx], req_beat);
          if (m_ar_addr_o !== exp_addr) report_mismatch("m_ar_addr", exp_addr, m_ar_addr_o);
          if (m_ar_id_o !== b_id[req_idx]) report_mismatch("m_ar_id", b_id[req_idx], m_ar_id_o);
          if (m_ar_size_o !== b_size[req_idx]) begin
            report_mismatch("m_ar_size", b_size[req_idx], m_ar_size_o);
          end
          if (m_ar_burst_o !== b_burst[req_idx]) begin
            report_mismatch("m_ar_burst", b_burst[req_idx], m_ar_burst_o);
          end
          if (req_beat == b_len[req_idx]) begin
            req_beat = 0;
            req_idx++;
          end else begin
            req_beat++;
          end
        end
        mem_data_q.push_back(model_data(m_ar_addr_o, m_ar_id_o));
        mem_id_q.push_back(m_ar_id_o);
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (rsp_idx >= acc_cnt) begin
          report_failure("an upstream read beat came back with no burst outstanding");
        end else begin
          exp_addr = beat_addr(b_addr[rsp_idx], b_size[rsp_idx], b_burst[rsp_idx], rsp_beat);
          exp_data = model_data(exp_addr, b_id[rsp_idx]);
          exp_last = (rsp_beat == b_len[rsp_idx]);
          if (s_r_data_o !== exp_data) report_mismatch("s_r_data", exp_data, s_r_data_o);
          if (s_r_id_o !== b_id[rsp_idx]) report_mismatch("s_r_id", b_id[rsp_idx], s_r_id_o);
          if (s_r_resp_o !== 2'b00) report_mismatch("s_r_resp", 0, s_r_resp_o);
          if (s_r_last_o !== exp_last) report_mismatch("s_r_last", exp_last, s_r_last_o);
          if (exp_last) begin
            rsp_beat = 0;
            rsp_idx++;
          end else begin
            rsp_beat++;
          end
        end
      end
      if (m_r_valid_i && m_r_ready_o) begin
        r_taken = 1'b1;
        if (mem_data_q.size() > 0) begin
          void'(mem_data_q.pop_front());
          void'(mem_id_q.pop_front());
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt == timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    s_ar_addr_i = '0;
    s_ar_id_i = '0;
    s_ar_len_i = '0;
    s_ar_size_i = '0;
    s_ar_burst_i = burst_incr;
    s_ar_valid_i = 1'b0;
    s_r_ready_i = 1'b1;
    m_ar_ready_i = 1'b0;
    m_r_data_i = '0;
    m_r_id_i = '0;
    m_r_resp_i = '0;
    m_r_valid_i = 1'b0;
    rng_state = 32'd65;
    mode = mode_idle;
    {acc_cnt, req_idx, req_beat, rsp_idx, rsp_beat, sent} = '0;
    {err_cnt, tests_passed, tests_failed, cycle_cnt} = '0;
    ar_taken = 1'b0;
    r_taken = 1'b0;
    test_name = "random_bursts";

    repeat (3) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // Offer a response beat that the empty FIFO has to hold back
    m_r_valid_i = 1'b1;
    @(posedge clk_i);
    #2;

    // Empty FIFO after reset, so nothing is valid and R is not ready
    err_start = err_cnt;
    if (m_ar_valid_o !== 1'b0) report_mismatch("m_ar_valid after reset", 0, m_ar_valid_o);
    if (s_r_valid_o !== 1'b0) report_mismatch("s_r_valid after reset", 0, s_r_valid_o);
    if (m_r_ready_o !== 1'b0) report_mismatch("m_r_ready after reset", 0, m_r_ready_o);
    m_r_valid_i = 1'b0;
    @(posedge clk_i);
    mode = mode_random;
    wait_drained();
    finish_test(err_start);

    // Upstream R blocked, so only the FIFO depth worth of bursts get in
    test_name = "outstanding_limit";
    err_start = err_cnt;
    acc_start = acc_cnt;
    mode = mode_limit;
    repeat (limit_cycles) @(posedge clk_i);
    if (acc_cnt - acc_start != max_txns) begin
      report_mismatch("accepted_bursts", max_txns, acc_cnt - acc_start);
    end
    mode = mode_drain;
    wait_drained();
    finish_test(err_start);

    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/burst_splitter.sv
// -------------------------------------------------------------------------
// Read burst splitter top level. Upstream bursts go out as single-beat
// requests; responses must return in request order and get their last
// flag rebuilt before going back upstream.
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module burst_splitter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,

  // Upstream AR
  input  burst_splitter_pkg::addr_t   s_ar_addr_i,
  input  burst_splitter_pkg::id_t     s_ar_id_i,
  input  burst_splitter_pkg::len_t    s_ar_len_i,
  input  burst_splitter_pkg::size_t   s_ar_size_i,
  input  burst_splitter_pkg::burst_e  s_ar_burst_i,
  input  wire logic                   s_ar_valid_i,
  output logic                        s_ar_ready_o,

  // Upstream R
  output burst_splitter_pkg::data_t   s_r_data_o,
  output burst_splitter_pkg::id_t     s_r_id_o,
  output burst_splitter_pkg::resp_t   s_r_resp_o,
  output logic                        s_r_last_o,
  output logic                        s_r_valid_o,
  input  wire logic                   s_r_ready_i,

  // Downstream AR
  output burst_splitter_pkg::addr_t   m_ar_addr_o,
  output burst_splitter_pkg::id_t     m_ar_id_o,
  output burst_splitter_pkg::size_t   m_ar_size_o,
  output burst_splitter_pkg::burst_e  m_ar_burst_o,
  output logic                        m_ar_valid_o,
  input  wire logic                   m_ar_ready_i,

  // Downstream R
  input  burst_splitter_pkg::data_t   m_r_data_i,
  input  burst_splitter_pkg::id_t     m_r_id_i,
  input  burst_splitter_pkg::resp_t   m_r_resp_i,
  input  wire logic                   m_r_valid_i,
  output logic                        m_r_ready_o
);

  import burst_splitter_pkg::*;

  logic push_valid;
  len_t push_len;
  logic push_ready;
  len_t head_len;
  logic head_valid;
  logic pop;

  ar_splitter i_ar_splitter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_size_i  (s_ar_size_i),
    .s_ar_burst_i (s_ar_burst_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .push_valid_o (push_valid),
    .push_len_o   (push_len),
    .push_ready_i (push_ready)
  );

  // Lengths of accepted bursts, oldest at the head
  burst_len_fifo i_burst_len_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_valid_i (push_valid),
    .push_len_i   (push_len),
    .push_ready_o (push_ready),
    .head_len_o   (head_len),
    .head_valid_o (head_valid),
    .pop_i        (pop)
  );

  r_last_rebuild i_r_last_rebuild (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_id_i     (m_r_id_i),
    .m_r_resp_i   (m_r_resp_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_data_o   (s_r_data_o),
    .s_r_id_o     (s_r_id_o),
    .s_r_resp_o   (s_r_resp_o),
    .s_r_last_o   (s_r_last_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .head_len_i   (head_len),
    .head_valid_i (head_valid),
    .pop_o        (pop)
  );

endmodule

`default_nettype wire

//--- source/r_last_rebuild.sv
// -------------------------------------------------------------------------
// Read data return path. Passes single-beat responses upstream and sets
// the last flag once the beat count reaches the length at the FIFO head.
// The handshake is combinational; only the beat counter is registered.
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module r_last_rebuild (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  // Downstream R, no last flag
  input  burst_splitter_pkg::data_t m_r_data_i,
  input  burst_splitter_pkg::id_t   m_r_id_i,
  input  burst_splitter_pkg::resp_t m_r_resp_i,
  input  wire logic                 m_r_valid_i,
  output logic                      m_r_ready_o,

  // Upstream R
  output burst_splitter_pkg::data_t s_r_data_o,
  output burst_splitter_pkg::id_t   s_r_id_o,
  output burst_splitter_pkg::resp_t s_r_resp_o,
  output logic                      s_r_last_o,
  output logic                      s_r_valid_o,
  input  wire logic                 s_r_ready_i,

  // Length FIFO head
  input  burst_splitter_pkg::len_t  head_len_i,
  input  wire logic                 head_valid_i,
  output logic                      pop_o
);

  import burst_splitter_pkg::*;

  // Beats already returned in the current burst
  len_t beat_cnt_q;
  logic r_xfer;

  // Beats without a known burst are held back
  assign s_r_valid_o = m_r_valid_i && head_valid_i;
  assign m_r_ready_o = s_r_ready_i && head_valid_i;

  assign s_r_data_o = m_r_data_i;
  assign s_r_id_o   = m_r_id_i;
  assign s_r_resp_o = m_r_resp_i;
  assign s_r_last_o = (beat_cnt_q == head_len_i);

  assign r_xfer = s_r_valid_o && s_r_ready_i;
  assign pop_o  = r_xfer && s_r_last_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_cnt_q <= '0;
    end else if (r_xfer) begin
      if (s_r_last_o) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/burst_len_fifo.sv
// -------------------------------------------------------------------------
// In-order FIFO of accepted burst lengths. Its depth bounds the number of
// outstanding upstream read bursts; the head feeds the last-flag rebuild.
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "burst_splitter_config.svh"

module burst_len_fifo (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  input  wire logic                 push_valid_i,
  input  burst_splitter_pkg::len_t  push_len_i,
  output logic                      push_ready_o,

  output burst_splitter_pkg::len_t  head_len_o,
  output logic                      head_valid_o,
  input  wire logic                 pop_i
);

  import burst_splitter_pkg::*;

  localparam int unsigned depth     = `BS_MAX_READ_TXNS;
  localparam int unsigned ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_width = $clog2(depth + 1);

  len_t                 mem_q [depth];
  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [cnt_width-1:0] fill_q;
  logic                 push_en;
  logic                 pop_en;

  // Circular increment, depth need not be a power of two
  function automatic logic [ptr_width-1:0] ptr_next(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (fill_q != cnt_width'(depth));
  assign head_valid_o = (fill_q != '0);
  assign head_len_o   = mem_q[rd_ptr_q];

  assign push_en = push_valid_i && push_ready_o;
  assign pop_en  = pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_en, pop_en})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_len_i;
    end
  end

endmodule

`default_nettype wire

//--- source/ar_splitter.sv
// -------------------------------------------------------------------------
// Read request splitter. Takes one upstream burst at a time and issues it
// downstream as single-beat requests, stepping the address for INCR bursts.
// The burst length is pushed into the length FIFO on acceptance.
// -------------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module ar_splitter (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,

  // Upstream AR
  input  burst_splitter_pkg::addr_t       s_ar_addr_i,
  input  burst_splitter_pkg::id_t         s_ar_id_i,
  input  burst_splitter_pkg::len_t        s_ar_len_i,
  input  burst_splitter_pkg::size_t       s_ar_size_i,
  input  burst_splitter_pkg::burst_e      s_ar_burst_i,
  input  wire logic                       s_ar_valid_i,
  output logic                            s_ar_ready_o,

  // Downstream AR, always single beat
  output burst_splitter_pkg::addr_t       m_ar_addr_o,
  output burst_splitter_pkg::id_t         m_ar_id_o,
  output burst_splitter_pkg::size_t       m_ar_size_o,
  output burst_splitter_pkg::burst_e      m_ar_burst_o,
  output logic                            m_ar_valid_o,
  input  wire logic                       m_ar_ready_i,

  // Length FIFO push side
  output logic                            push_valid_o,
  output burst_splitter_pkg::len_t        push_len_o,
  input  wire logic                       push_ready_i
);

  import burst_splitter_pkg::*;

  ar_state_e state_q;
  ar_state_e state_d;

  // Registered request, advanced after every downstream beat
  addr_t     addr_q;
  id_t       id_q;
  len_t      remain_q;
  size_t     size_q;
  burst_e    burst_q;

  logic      m_ar_xfer;
  logic      final_beat;
  logic      can_accept;
  logic      s_ar_xfer;

  assign m_ar_xfer  = m_ar_valid_o && m_ar_ready_i;
  assign final_beat = m_ar_xfer && (remain_q == '0);

  // The next burst may enter while the last split beat goes out
  assign can_accept   = (state_q == ar_idle) || final_beat;
  assign s_ar_ready_o = can_accept && push_ready_i;
  assign s_ar_xfer    = s_ar_valid_i && s_ar_ready_o;

  assign push_valid_o = s_ar_valid_i && can_accept;
  assign push_len_o   = s_ar_len_i;

  assign m_ar_valid_o = (state_q == ar_busy);
  assign m_ar_addr_o  = addr_q;
  assign m_ar_id_o    = id_q;
  assign m_ar_size_o  = size_q;
  assign m_ar_burst_o = burst_q;

  // -------------------------------------------------------------------------
  // FSM
  // -------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ar_idle: begin
        if (s_ar_xfer) begin
          state_d = ar_busy;
        end
      end
      ar_busy: begin
        if (final_beat && !s_ar_xfer) begin
          state_d = ar_idle;
        end
      end
      default: state_d = ar_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ar_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // -------------------------------------------------------------------------
  // Request registers
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (s_ar_xfer) begin
      addr_q   <= s_ar_addr_i;
      id_q     <= s_ar_id_i;
      remain_q <= s_ar_len_i;
      size_q   <= s_ar_size_i;
      burst_q  <= s_ar_burst_i;
    end else if (m_ar_xfer && !final_beat) begin
      remain_q <= remain_q - len_t'(1);
      // FIXED keeps the address, wrap is treated the same way
      if (burst_q == burst_incr) begin
        addr_q <= addr_q + (addr_t'(1) << size_q);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/burst_splitter_pkg.sv
// -------------------------------------------------------------------------
// Shared types of the read burst splitter.
// Modules import this package for the bus field types and state encodings.
// -------------------------------------------------------------------------

`default_nettype none

`include "burst_splitter_config.svh"

package burst_splitter_pkg;

  // Bus field types
  typedef logic [`BS_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`BS_DATA_WIDTH-1:0] data_t;
  typedef logic [`BS_ID_WIDTH-1:0]   id_t;

  // Beats in the burst minus one
  typedef logic [7:0] len_t;
  // log2 of the bytes moved per beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] resp_t;

  // AXI burst type encoding, wrap is not supported by the splitter
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } burst_e;

  // Request splitter FSM
  typedef enum logic {
    ar_idle = 1'b0,
    ar_busy = 1'b1
  } ar_state_e;

endpackage

`default_nettype wire

//--- source/burst_splitter_config.svh
// -------------------------------------------------------------------------
// Build-time parameters of the read burst splitter.
// Include this wherever widths or the outstanding-burst depth are needed.
// -------------------------------------------------------------------------

`ifndef BURST_SPLITTER_CONFIG_SVH
`define BURST_SPLITTER_CONFIG_SVH

// Address and data bus widths in bits
`define BS_ADDR_WIDTH 32
`define BS_DATA_WIDTH 32

// Transaction ID width in bits
`define BS_ID_WIDTH 4

// Upstream read bursts that may be accepted but not yet fully returned
`define BS_MAX_READ_TXNS 4

`endif
